/* rtl/branch_predictor.sv */
`default_nettype none
`include "fetch_config.svh"

module branch_predictor #(
	parameter int SIZE = `BTB_SIZE
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        stall,
	input  logic                        flush,
	input  fetch_pkg::virt_t            pc_cur,
	branch_update_if.sink               upd,
	input  logic                        presolve_mispredict,
	input  fetch_pkg::virt_t            presolve_pc,
	output fetch_pkg::branch_predict_t  prediction,
	output logic [1:0]                  prediction_sel
);

	localparam int OFS_W = $clog2(`FETCH_NUM) + 2;
	localparam int IDX_W = $clog2(SIZE);
	localparam int TAG_W = 32 - OFS_W - IDX_W;

	logic [TAG_W-1:0] tag_mem    [SIZE];
	fetch_pkg::virt_t target_mem [SIZE];
	logic [1:0]       slot_valid [SIZE];

	logic [IDX_W-1:0] lk_idx, upd_idx, pre_idx;
	logic [1:0]       lk_hit;
	logic             upd_tag_hit, pre_tag_hit;

	function automatic logic [IDX_W-1:0] btb_index(input fetch_pkg::virt_t a);
		return a[OFS_W +: IDX_W];
	endfunction

	function automatic logic [TAG_W-1:0] btb_tag(input fetch_pkg::virt_t a);
		return a[31 -: TAG_W];
	endfunction

	assign lk_idx      = btb_index(pc_cur);
	assign upd_idx     = btb_index(upd.pc);
	assign pre_idx     = btb_index(presolve_pc);
	assign lk_hit      = slot_valid[lk_idx] & {2{tag_mem[lk_idx] == btb_tag(pc_cur)}};
	assign upd_tag_hit = tag_mem[upd_idx] == btb_tag(upd.pc);
	assign pre_tag_hit = tag_mem[pre_idx] == btb_tag(presolve_pc);

	// tag and target only change on a taken update
	always_ff @(posedge clk) begin
		if (upd.valid && upd.taken) begin
			tag_mem[upd_idx]    <= btb_tag(upd.pc);
			target_mem[upd_idx] <= upd.target;
		end
	end

	// one slot per entry, a new branch replaces the pair
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < SIZE; i++)
				slot_valid[i] <= '0;
		end else begin
			if (upd.valid && upd.taken)
				slot_valid[upd_idx] <= upd.pc[2] ? 2'b10 : 2'b01;
			else if (upd.valid && upd_tag_hit)
				slot_valid[upd_idx][upd.pc[2]] <= 1'b0;
			if (presolve_mispredict && pre_tag_hit)
				slot_valid[pre_idx][presolve_pc[2]] <= 1'b0;
		end
	end

	// registered lookup, lines up with the stage-2 PC
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			prediction.valid <= 1'b0;
			prediction_sel   <= '0;
		end else if (!stall) begin
			prediction.valid  <= |lk_hit;
			prediction.taken  <= 1'b1;
			prediction.target <= target_mem[lk_idx];
			prediction_sel    <= lk_hit;
		end
	end

endmodule

`default_nettype wire

/* rtl/branch_update_if.sv */
`default_nettype none

// resolved branch from the backend, one pulse per branch
interface branch_update_if;

	logic             valid;
	logic             mispredict;
	logic             taken;
	fetch_pkg::virt_t pc;
	fetch_pkg::virt_t target;

	modport source (
		output valid, mispredict, taken, pc, target
	);

	modport sink (
		input valid, mispredict, taken, pc, target
	);

endinterface

`default_nettype wire

/* rtl/decode_branch.sv */
`default_nettype none

module decode_branch (
	input  logic [31:0]           instr,
	output fetch_pkg::ctrl_flow_e cf,
	output fetch_pkg::virt_t      imm_target_offset
);

	fetch_pkg::opcode_e opcode;
	logic [5:0]         funct;
	logic [4:0]         rt;

	assign opcode = fetch_pkg::opcode_e'(instr[31:26]);
	assign funct  = instr[5:0];
	assign rt     = instr[20:16];

	always_comb begin
		cf = fetch_pkg::CF_NONE;
		case (opcode)
			// jr and jalr
			fetch_pkg::SPECIAL: begin
				if (funct == 6'h08 || funct == 6'h09)
					cf = fetch_pkg::CF_JUMP_R;
			end
			// bltz, bgez and their linking forms
			fetch_pkg::REGIMM: begin
				if (rt[4:1] == 4'b0000 || rt[4:1] == 4'b1000)
					cf = fetch_pkg::CF_BRANCH;
			end
			fetch_pkg::J, fetch_pkg::JAL:
				cf = fetch_pkg::CF_JUMP_I;
			fetch_pkg::BEQ, fetch_pkg::BNE, fetch_pkg::BLEZ, fetch_pkg::BGTZ:
				cf = fetch_pkg::CF_BRANCH;
			default:
				cf = fetch_pkg::CF_NONE;
		endcase
	end

	// word offset, relative to the word after the branch
	assign imm_target_offset = (cf == fetch_pkg::CF_BRANCH) ?
		{{14{instr[15]}}, instr[15:0], 2'b00} : '0;

endmodule

`default_nettype wire

/* rtl/fetch_config.svh */
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// words per fetch, one aligned pair
`define FETCH_NUM 2

// BTB entries, one per word pair
`define BTB_SIZE 64

// instruction queue entries, power of two
`define IQ_DEPTH 8

// boot vector
`define RESET_PC 32'hbfc0_0000

`endif

/* rtl/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

	typedef logic [31:0] virt_t;

	typedef struct packed {
		logic  valid;
		logic  taken;
		virt_t target;
	} branch_predict_t;

	typedef struct packed {
		logic            valid;
		virt_t           vaddr;
		logic [31:0]     instr;
		branch_predict_t branch_predict;
	} fetch_entry_t;

	typedef enum logic [1:0] {
		CF_NONE,
		CF_BRANCH,
		CF_JUMP_I,
		CF_JUMP_R
	} ctrl_flow_e;

	// major opcodes seen by the pre-decoder
	typedef enum logic [5:0] {
		SPECIAL = 6'h00,
		REGIMM  = 6'h01,
		J       = 6'h02,
		JAL     = 6'h03,
		BEQ     = 6'h04,
		BNE     = 6'h05,
		BLEZ    = 6'h06,
		BGTZ    = 6'h07
	} opcode_e;

endpackage

`default_nettype wire

/* rtl/instr_fetch.sv */
`default_nettype none
`include "fetch_config.svh"

module instr_fetch (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    except_valid,
	input  fetch_pkg::virt_t        except_vec,
	input  logic                    resolve_valid,
	input  logic                    resolve_mispredict,
	input  logic                    resolve_taken,
	input  fetch_pkg::virt_t        resolve_pc,
	input  fetch_pkg::virt_t        resolve_target,
	output logic                    icache_read,
	output fetch_pkg::virt_t        icache_vaddr,
	input  logic [63:0]             icache_data,
	input  logic                    icache_stall,
	output fetch_pkg::fetch_entry_t fetch_entry0,
	output fetch_pkg::fetch_entry_t fetch_entry1,
	input  logic [1:0]              fetch_ack
);

	localparam int ALIGN_W = $clog2(`FETCH_NUM) + 2;

	branch_update_if upd_if ();

	fetch_pkg::virt_t pc_s1, presolve_pc, presolve_target, s2_pc, s3_pc;
	logic             pc_en, stall, flush_s1, flush_s3;
	logic             presolve, replay, predict_taken, s2_valid, q_full;
	logic [1:0]       s2_sel, slot_taken, bad_pred, push_num, pop_valid;

	fetch_pkg::branch_predict_t    s2_bp;
	fetch_pkg::fetch_entry_t [1:0] s2_ent, s3_ent, push_ent, pop_ent;
	fetch_pkg::ctrl_flow_e         s3_cf  [2];
	fetch_pkg::virt_t              s3_off [2];

	assign upd_if.valid      = resolve_valid;
	assign upd_if.mispredict = resolve_mispredict;
	assign upd_if.taken      = resolve_taken;
	assign upd_if.pc         = resolve_pc;
	assign upd_if.target     = resolve_target;

	// a cache stall freezes every stage
	assign stall    = icache_stall;
	assign flush_s3 = except_valid | (resolve_valid & resolve_mispredict);
	assign flush_s1 = flush_s3 | presolve | replay | predict_taken;

	pc_generator u_pc_gen (
		.clk, .rst,
		.hold                ( stall           ),
		.except_valid, .except_vec,
		.upd                 ( upd_if          ),
		.presolve_mispredict ( presolve        ),
		.presolve_target,
		.replay_valid        ( replay          ),
		.replay_vaddr        ( s3_pc           ),
		.predict_taken,
		.predict_target      ( s2_bp.target    ),
		.pc                  ( pc_s1           ),
		.pc_en
	);

	branch_predictor u_btb (
		.clk, .rst, .stall,
		.flush               ( flush_s1 ),
		.pc_cur              ( pc_s1    ),
		.upd                 ( upd_if   ),
		.presolve_mispredict ( presolve ),
		.presolve_pc,
		.prediction          ( s2_bp    ),
		.prediction_sel      ( s2_sel   )
	);

	assign icache_read  = pc_en;
	assign icache_vaddr = {pc_s1[31:ALIGN_W], {ALIGN_W{1'b0}}};

	always_ff @(posedge clk) begin
		if (rst || flush_s1)
			s2_valid <= 1'b0;
		else if (!stall)
			s2_valid <= pc_en;
	end

	always_ff @(posedge clk) begin
		if (!stall)
			s2_pc <= pc_s1;
	end

	// stage 2, cache data for s2_pc is on icache_data
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			s2_ent[i].vaddr = {s2_pc[31:ALIGN_W], {ALIGN_W{1'b0}}} + 32'(4 * i);
			s2_ent[i].instr = icache_data[32 * i +: 32];
			s2_ent[i].branch_predict = s2_bp;
			s2_ent[i].branch_predict.valid = s2_bp.valid & s2_sel[i];
		end
		s2_ent[0].valid = s2_valid & ~s2_pc[2];
		s2_ent[1].valid = s2_valid;
		if (!s2_ent[0].valid)
			s2_ent[0].branch_predict.valid = 1'b0;
	end

	assign slot_taken[0] = s2_ent[0].valid & s2_ent[0].branch_predict.valid
		& s2_ent[0].branch_predict.taken;
	assign slot_taken[1] = ~slot_taken[0] & s2_ent[1].branch_predict.valid
		& s2_ent[1].branch_predict.taken;
	assign predict_taken = ~stall & (|slot_taken);

	always_ff @(posedge clk) begin
		if (rst || flush_s3 || presolve || replay) begin
			s3_ent[0].valid <= 1'b0;
			s3_ent[1].valid <= 1'b0;
		end else if (!stall) begin
			s3_ent <= s2_ent;
			s3_pc  <= s2_pc;
		end
	end

	// pre-decode catches predictions on non-branches or with a wrong target
	for (genvar i = 0; i < 2; i++) begin : gen_decode
		decode_branch u_decode (
			.instr             ( s3_ent[i].instr ),
			.cf                ( s3_cf[i]        ),
			.imm_target_offset ( s3_off[i]       )
		);

		assign bad_pred[i] = s3_ent[i].valid & s3_ent[i].branch_predict.valid
			& (s3_cf[i] == fetch_pkg::CF_NONE
			| (s3_cf[i] == fetch_pkg::CF_BRANCH
			& s3_ent[i].branch_predict.target != s3_ent[i].vaddr + 32'd4 + s3_off[i]));
	end

	// a full queue refuses the push, so presolve waits for the replay
	assign presolve        = ~stall & ~q_full & (|bad_pred);
	assign replay          = ~stall & q_full & (s3_ent[0].valid | s3_ent[1].valid);
	assign presolve_pc     = bad_pred[0] ? s3_ent[0].vaddr : s3_ent[1].vaddr;
	assign presolve_target = {s3_pc[31:ALIGN_W] + 1'b1, {ALIGN_W{1'b0}}};

	always_comb begin
		push_ent = s3_ent;
		for (int i = 0; i < 2; i++) begin
			if (bad_pred[i])
				push_ent[i].branch_predict.valid = 1'b0;
		end
		// slot 1 survives a cancelled slot-0 prediction
		if (push_ent[0].branch_predict.valid && push_ent[0].branch_predict.taken)
			push_ent[1].valid = 1'b0;
		if (!push_ent[0].valid) begin
			push_ent[0]       = push_ent[1];
			push_ent[1].valid = 1'b0;
		end
		push_num = stall ? 2'd0 : 2'(push_ent[0].valid) + 2'(push_ent[1].valid);
	end

	instr_queue u_queue (
		.clk, .rst,
		.flush     ( flush_s3  ),
		.push_data ( push_ent  ),
		.push_num,
		.full      ( q_full    ),
		.pop_data  ( pop_ent   ),
		.pop_valid,
		.pop_num   ( fetch_ack )
	);

	always_comb begin
		fetch_entry0       = pop_ent[0];
		fetch_entry0.valid = pop_ent[0].valid & pop_valid[0];
		fetch_entry1       = pop_ent[1];
		fetch_entry1.valid = pop_ent[1].valid & pop_valid[1];
	end

endmodule

`default_nettype wire

/* rtl/instr_queue.sv */
`default_nettype none
`include "fetch_config.svh"

module instr_queue #(
	parameter int DEPTH = `IQ_DEPTH
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          flush,
	input  fetch_pkg::fetch_entry_t [1:0] push_data,
	input  logic [1:0]                    push_num,
	output logic                          full,
	output fetch_pkg::fetch_entry_t [1:0] pop_data,
	output logic [1:0]                    pop_valid,
	input  logic [1:0]                    pop_num
);

	// pointers wrap naturally, DEPTH is a power of two
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	fetch_pkg::fetch_entry_t mem [DEPTH];

	logic [PTR_W-1:0] head, tail;
	logic [CNT_W-1:0] count;
	logic [1:0]       push_acc;

	// fewer than two free slots
	assign full     = count > CNT_W'(DEPTH - 2);
	assign push_acc = full ? 2'd0 : push_num;

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			head  <= head + PTR_W'(pop_num);
			tail  <= tail + PTR_W'(push_acc);
			count <= count + CNT_W'(push_acc) - CNT_W'(pop_num);
		end
	end

	always_ff @(posedge clk) begin
		if (push_acc != 2'd0)
			mem[tail] <= push_data[0];
		if (push_acc == 2'd2)
			mem[PTR_W'(tail + 1'b1)] <= push_data[1];
	end

	assign pop_data[0]  = mem[head];
	assign pop_data[1]  = mem[PTR_W'(head + 1'b1)];
	assign pop_valid[0] = count != '0;
	assign pop_valid[1] = count > CNT_W'(1);

endmodule

`default_nettype wire

/* rtl/pc_generator.sv */
`default_nettype none
`include "fetch_config.svh"

module pc_generator (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  hold,
	input  logic                  except_valid,
	input  fetch_pkg::virt_t      except_vec,
	branch_update_if.sink         upd,
	input  logic                  presolve_mispredict,
	input  fetch_pkg::virt_t      presolve_target,
	input  logic                  replay_valid,
	input  fetch_pkg::virt_t      replay_vaddr,
	input  logic                  predict_taken,
	input  fetch_pkg::virt_t      predict_target,
	output fetch_pkg::virt_t      pc,
	output logic                  pc_en
);

	localparam int ALIGN_W = $clog2(`FETCH_NUM) + 2;

	fetch_pkg::virt_t seq_pc;

	// next aligned pair
	assign seq_pc = {pc[31:ALIGN_W] + 1'b1, {ALIGN_W{1'b0}}};

	always_ff @(posedge clk) begin
		if (rst) begin
			pc    <= `RESET_PC;
			pc_en <= 1'b0;
		end else begin
			pc_en <= 1'b1;
			// backend redirects must not be lost while the cache stalls
			if (except_valid) begin
				pc <= except_vec;
			end else if (upd.valid && upd.mispredict) begin
				pc <= upd.target;
			end else if (!hold && pc_en) begin
				if (presolve_mispredict)
					pc <= presolve_target;
				else if (replay_valid)
					pc <= replay_vaddr;
				else if (predict_taken)
					pc <= predict_target;
				else
					pc <= seq_pc;
			end
		end
	end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the fetch unit testbench with Verilator
rm -rf obj_dir run.log
verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module tb_instr_fetch -o sim_fetch > build.log 2>&1 \
	&& ./obj_dir/sim_fetch > run.log 2>&1
cat run.log 2>/dev/null
grep -q "^SIMULATION PASSED$" run.log && echo "run.sh: passed" \
	|| { echo "run.sh: failed, see build.log and run.log"; exit 1; }

/* sim/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// test program, an addiu everywhere except one beq per 256 bytes
function automatic logic [31:0] program_word(input logic [31:0] addr);
	// beq $0, $0 with a 16 word offset
	if (addr[7:2] == 6'h3c)
		return 32'h1000_0010;
	// addiu $0, $0 with the word address as immediate
	return {6'h09, 5'd0, 5'd0, addr[17:2]};
endfunction

`endif

/* sim/fetch_assertions.sv */
`default_nettype none
`include "fetch_config.svh"
`include "tb_program.svh"

module fetch_assertions (
	input wire logic                    clk,
	input wire logic                    rst,
	input wire logic                    except_valid,
	input wire fetch_pkg::virt_t        except_vec,
	input wire logic                    resolve_valid,
	input wire logic                    resolve_mispredict,
	input wire fetch_pkg::virt_t        resolve_target,
	input wire logic                    icache_read,
	input wire fetch_pkg::fetch_entry_t fetch_entry0,
	input wire fetch_pkg::fetch_entry_t fetch_entry1,
	input wire logic [1:0]              fetch_ack
);

	timeunit 1ns;
	timeprecision 100ps;

	fetch_pkg::virt_t exp_vaddr;

	// where the entry after e must come from
	function automatic fetch_pkg::virt_t next_vaddr(input fetch_pkg::fetch_entry_t e);
		if (e.branch_predict.valid && e.branch_predict.taken)
			return e.branch_predict.target;
		return e.vaddr + 32'd4;
	endfunction

	function automatic logic is_beq(input fetch_pkg::fetch_entry_t e);
		return e.instr[31:26] == 6'h04;
	endfunction

	// test program beq, 16 words past the next word
	function automatic fetch_pkg::virt_t beq_target(input fetch_pkg::fetch_entry_t e);
		return e.vaddr + 32'd4 + 32'd64;
	endfunction

	// expected vaddr of the next popped entry
	always_ff @(posedge clk) begin
		if (rst) begin
			exp_vaddr <= `RESET_PC;
		end else if (except_valid) begin
			exp_vaddr <= except_vec;
		end else if (resolve_valid && resolve_mispredict) begin
			exp_vaddr <= resolve_target;
		end else if (fetch_ack == 2'd1) begin
			exp_vaddr <= next_vaddr(fetch_entry0);
		end else if (fetch_ack == 2'd2) begin
			exp_vaddr <= next_vaddr(fetch_entry1);
		end
	end

	a_reset_quiet: assert property (@(posedge clk)
		rst |=> !icache_read && !fetch_entry0.valid && !fetch_entry1.valid)
		else $error("ERR %0t: fetch active in the first cycle after reset", $time);

	a_word0: assert property (@(posedge clk) disable iff (rst)
		fetch_ack != 2'd0 |->
		fetch_entry0.valid && fetch_entry0.instr == program_word(fetch_entry0.vaddr))
		else $error("ERR %0t: entry0 at %h holds %h", $time, fetch_entry0.vaddr,
			fetch_entry0.instr);

	a_word1: assert property (@(posedge clk) disable iff (rst)
		fetch_ack == 2'd2 |->
		fetch_entry1.valid && fetch_entry1.instr == program_word(fetch_entry1.vaddr))
		else $error("ERR %0t: entry1 at %h holds %h", $time, fetch_entry1.vaddr,
			fetch_entry1.instr);

	a_order0: assert property (@(posedge clk) disable iff (rst)
		fetch_ack != 2'd0 |-> fetch_entry0.vaddr == exp_vaddr)
		else $error("ERR %0t: popped %h, expected %h", $time, fetch_entry0.vaddr, exp_vaddr);

	a_order1: assert property (@(posedge clk) disable iff (rst)
		fetch_ack == 2'd2 |-> fetch_entry1.vaddr == next_vaddr(fetch_entry0))
		else $error("ERR %0t: entry1 %h does not follow entry0 %h", $time,
			fetch_entry1.vaddr, fetch_entry0.vaddr);

	// a prediction only survives pre-decode on the beq, with its real target
	a_pred0: assert property (@(posedge clk) disable iff (rst)
		fetch_ack != 2'd0 && fetch_entry0.branch_predict.valid |->
		is_beq(fetch_entry0)
		&& fetch_entry0.branch_predict.target == beq_target(fetch_entry0))
		else $error("ERR %0t: entry0 at %h predicted to %h", $time, fetch_entry0.vaddr,
			fetch_entry0.branch_predict.target);

	a_pred1: assert property (@(posedge clk) disable iff (rst)
		fetch_ack == 2'd2 && fetch_entry1.branch_predict.valid |->
		is_beq(fetch_entry1)
		&& fetch_entry1.branch_predict.target == beq_target(fetch_entry1))
		else $error("ERR %0t: entry1 at %h predicted to %h", $time, fetch_entry1.vaddr,
			fetch_entry1.branch_predict.target);

endmodule

`default_nettype wire

/* sim/tb_instr_fetch.sv */
`default_nettype none
`include "tb_program.svh"

module tb_instr_fetch;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int RUN_CYCLES     = 12000;
	localparam int TIMEOUT_CYCLES = RUN_CYCLES * 5 / 3;
	localparam int FAKE_CYCLE     = 2000;
	localparam int EXC_CYCLE      = 6000;

	logic                    clk = 1'b0;
	logic                    rst;
	logic                    except_valid, resolve_valid, resolve_mispredict, resolve_taken;
	fetch_pkg::virt_t        except_vec, resolve_pc, resolve_target, icache_vaddr;
	logic                    icache_read, icache_stall;
	logic [63:0]             icache_data;
	fetch_pkg::fetch_entry_t fetch_entry0, fetch_entry1;
	logic [1:0]              fetch_ack;

	logic [31:0]      rng = 32'h5a4c_ae51;
	int               cycle, redirects, presolves, full_events, trained_hits, errors;
	logic             fake_done, exc_done, have_beq, reported;
	fetch_pkg::virt_t last_beq;

	instr_fetch DUT (.*);

	bind instr_fetch fetch_assertions u_assertions (.*);

	always #2 clk = ~clk;

	// Galois LFSR, taps 32 30 26 25
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
	endfunction

	function logic [3:0] random_bits(input int n);
		logic [3:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v   = {v[2:0], rng[0]};
			rng = lfsr_step(rng);
		end
		return v;
	endfunction

	function automatic logic is_beq(input fetch_pkg::fetch_entry_t e);
		return e.instr[31:26] == 6'h04;
	endfunction

	// addiu a little past the last beq, on the path from its target
	function automatic logic fake_candidate(input fetch_pkg::fetch_entry_t e);
		return !is_beq(e) && (e.vaddr - last_beq) >= 32'h50 && (e.vaddr - last_beq) < 32'h100;
	endfunction

	// cache answers a read one cycle after the request, holds while stalled
	always @(posedge clk) begin
		if (!icache_stall && icache_read)
			icache_data <= {program_word(icache_vaddr + 32'd4), program_word(icache_vaddr)};
	end

	// backend: pops, resolves branches, raises the exception
	always @(posedge clk) begin : backend
		fetch_pkg::fetch_entry_t beq_e, fake_e;
		logic                    got_beq, got_fake, busy;
		int                      avail, want;
		got_beq  = 1'b0;
		got_fake = 1'b0;
		if (fetch_ack != 2'd0 && is_beq(fetch_entry0)) begin
			beq_e   = fetch_entry0;
			got_beq = 1'b1;
		end else if (fetch_ack == 2'd2 && is_beq(fetch_entry1)) begin
			beq_e   = fetch_entry1;
			got_beq = 1'b1;
		end
		if (cycle >= FAKE_CYCLE && !fake_done && have_beq) begin
			if (fetch_ack != 2'd0 && fake_candidate(fetch_entry0)) begin
				fake_e   = fetch_entry0;
				got_fake = 1'b1;
			end else if (fetch_ack == 2'd2 && fake_candidate(fetch_entry1)) begin
				fake_e   = fetch_entry1;
				got_fake = 1'b1;
			end
		end
		resolve_valid <= 1'b0;
		except_valid  <= 1'b0;
		busy = 1'b0;
		if (rst) begin
			cycle <= 0;
		end else begin
			cycle <= cycle + 1;
			if (got_beq) begin
				busy = 1'b1;
				resolve_valid      <= 1'b1;
				resolve_taken      <= 1'b1;
				resolve_pc         <= beq_e.vaddr;
				resolve_target     <= beq_e.vaddr + 32'd68;
				resolve_mispredict <= !(beq_e.branch_predict.valid && beq_e.branch_predict.taken);
				if (beq_e.branch_predict.valid && beq_e.branch_predict.taken)
					trained_hits++;
				else
					redirects++;
				last_beq = beq_e.vaddr;
				have_beq = 1'b1;
			end else if (got_fake) begin
				// trains a false entry and jumps back over the trained beq
				busy = 1'b1;
				resolve_valid      <= 1'b1;
				resolve_taken      <= 1'b1;
				resolve_mispredict <= 1'b1;
				resolve_pc         <= fake_e.vaddr;
				resolve_target     <= last_beq - 32'd8;
				fake_done = 1'b1;
				redirects++;
			end else if (cycle >= EXC_CYCLE && !exc_done) begin
				busy = 1'b1;
				except_valid <= 1'b1;
				except_vec   <= 32'h8000_0180;
				exc_done = 1'b1;
				redirects++;
			end
			if (DUT.presolve)
				presolves++;
			if (DUT.replay)
				full_events++;
		end
		// only pop what is surely in the queue next cycle
		avail = int'(fetch_entry0.valid) + int'(fetch_entry1.valid) - int'(fetch_ack);
		want  = int'(random_bits(2));
		if (want == 3)
			want = 2;
		if (rst || busy || except_valid || (resolve_valid && resolve_mispredict))
			want = 0;
		else if (want > avail)
			want = avail;
		fetch_ack    <= 2'(want);
		icache_stall <= rst ? 1'b0 : (random_bits(3) == 4'd0);
	end

	initial begin
		rst                = 1'b1;
		except_valid       = 1'b0;
		except_vec         = '0;
		resolve_valid      = 1'b0;
		resolve_mispredict = 1'b0;
		resolve_taken      = 1'b0;
		resolve_pc         = '0;
		resolve_target     = '0;
		icache_data        = '0;
		icache_stall       = 1'b0;
		fetch_ack          = 2'd0;
		fake_done          = 1'b0;
		exc_done           = 1'b0;
		have_beq           = 1'b0;
		reported           = 1'b0;
		last_beq           = '0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		repeat (RUN_CYCLES) @(posedge clk);
		if (redirects == 0) begin
			$display("unreached: no redirect was issued");
			errors++;
		end
		if (presolves == 0) begin
			$display("unreached: pre-decode never cancelled a prediction");
			errors++;
		end
		if (full_events == 0) begin
			$display("unreached: the queue never refused a push");
			errors++;
		end
		if (trained_hits == 0) begin
			$display("unreached: no trained beq was popped as predicted taken");
			errors++;
		end
		$display("redirects %0d presolves %0d full %0d trained hits %0d errors %0d",
			redirects, presolves, full_events, trained_hits, errors);
		reported = 1'b1;
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// watchdog
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("watchdog: run did not end within %0d cycles", TIMEOUT_CYCLES);
		reported = 1'b1;
		$display("SIMULATION FAILED");
		$finish;
	end

	// a failed assertion stops the run early
	final begin
		if (!reported)
			$display("SIMULATION FAILED");
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+rtl
+incdir+sim
rtl/fetch_pkg.sv
rtl/branch_update_if.sv
rtl/pc_generator.sv
rtl/branch_predictor.sv
rtl/decode_branch.sv
rtl/instr_queue.sv
rtl/instr_fetch.sv
sim/fetch_assertions.sv
sim/tb_instr_fetch.sv
